// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f sources.f --top-module qracc_tb -o qracc_sim
out=$(./obj_dir/qracc_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
else
    echo "Simulation reported failure"
    exit 1
fi

// ==== source/qracc_act_buffer.sv ====
// Single-port activation memory, read data one cycle after the enable
// Read data holds its value between reads
module qracc_act_buffer (
    input  logic                  clk,
    input  qracc_pkg::buf_port_t  port_i,
    output qracc_pkg::pixel_t     rd_data_o
);
    import qracc_pkg::*;

    pixel_t mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (port_i.en) begin
            if (port_i.we) begin
                mem[port_i.addr] <= port_i.wdata;
            end else begin
                rd_data_o <= mem[port_i.addr];
            end
        end
    end

endmodule

// ==== source/qracc_controller.sv ====
// Microcode looper over load, compute and readback
// Host accesses outside their state are dropped
module qracc_controller (
    input  logic                       clk,
    input  logic                       nrst,
    input  qracc_pkg::qracc_config_t   cfg_i,
    input  logic                       start_i,
    input  logic                       load_i,
    input  qracc_pkg::data_access_t    data_i,
    input  qracc_pkg::tap_t            tap_i,
    input  logic                       done_i,
    input  qracc_pkg::mac_result_t     result_i,
    output logic                       run_o,
    output qracc_pkg::buf_port_t       buf_o,
    output qracc_pkg::ctrl_state_t     state_o
);
    import qracc_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    buf_addr_t   wr_ptr_q;
    buf_addr_t   rd_ptr_q;
    buf_addr_t   n_pix;
    buf_addr_t   n_out;
    logic        done_seen_q;
    logic        pend_q;
    logic        host_wr;
    logic        host_rd;

    assign n_pix   = cfg_i.dimx * cfg_i.dimy;
    assign n_out   = (cfg_i.dimx - 4'd2) * (cfg_i.dimy - 4'd2);
    assign host_wr = data_i.valid && data_i.write && (state_q == LOADACTS);
    assign host_rd = data_i.valid && !data_i.write && (state_q == READACTS);
    assign run_o   = (state_q == COMPUTE) && !done_seen_q;
    assign state_o = state_q;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = COMPUTE;
                end else if (load_i) begin
                    state_d = LOADACTS;
                end
            end
            LOADACTS: begin
                if (host_wr && (wr_ptr_q == n_pix - 7'd1)) begin
                    state_d = IDLE;
                end
            end
            // Counter finished and last window written back
            COMPUTE: begin
                if (done_seen_q && !pend_q) begin
                    state_d = READACTS;
                end
            end
            READACTS: begin
                if (host_rd && (rd_ptr_q == OFMAP_BASE + n_out - 7'd1)) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q     <= IDLE;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= OFMAP_BASE;
            done_seen_q <= 1'b0;
            pend_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == LOADACTS) && (state_d != LOADACTS)) begin
                wr_ptr_q <= '0;
            end else if (host_wr) begin
                wr_ptr_q <= wr_ptr_q + 7'd1;
            end
            if ((state_q == READACTS) && (state_d != READACTS)) begin
                rd_ptr_q <= OFMAP_BASE;
            end else if (host_rd) begin
                rd_ptr_q <= rd_ptr_q + 7'd1;
            end
            done_seen_q <= (state_d == COMPUTE) && (done_seen_q || done_i);
            // One window at most between its last tap and its result
            if (tap_i.valid && tap_i.last) begin
                pend_q <= 1'b1;
            end else if (result_i.valid) begin
                pend_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Buffer port mux
    ////////////////////////////////////////

    always_comb begin
        buf_o = '0;
        if (result_i.valid) begin
            buf_o.en    = 1'b1;
            buf_o.we    = 1'b1;
            buf_o.addr  = result_i.oidx;
            buf_o.wdata = result_i.value;
        end else if (tap_i.valid) begin
            buf_o.en   = 1'b1;
            buf_o.addr = tap_i.rd_addr;
        end else if (host_wr) begin
            buf_o.en    = 1'b1;
            buf_o.we    = 1'b1;
            buf_o.addr  = wr_ptr_q;
            buf_o.wdata = data_i.wdata;
        end else if (host_rd) begin
            buf_o.en   = 1'b1;
            buf_o.addr = rd_ptr_q;
        end
    end

endmodule

// ==== source/qracc_csr.sv ====
// APB slave, no error responses; REG_DATA reads take one wait state
// Data reads outside READACTS return 0
module qracc_csr (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [7:0]                 paddr_i,
    input  logic [31:0]                pwdata_i,
    output logic [31:0]                prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    input  qracc_pkg::ctrl_state_t     state_i,
    input  qracc_pkg::pixel_t          rd_data_i,
    output qracc_pkg::qracc_config_t   cfg_o,
    output qracc_pkg::weights_t        weights_o,
    output logic                       start_o,
    output logic                       load_o,
    output qracc_pkg::data_access_t    data_o
);
    import qracc_pkg::*;

    logic       access;
    logic       wr_en;
    logic       is_data;
    logic       is_weight;
    logic       data_rd;
    logic       busy;
    logic [7:0] woff;
    logic [3:0] widx;
    logic       rd_wait_q;
    logic       rd_ok_q;

    assign access    = psel_i && penable_i;
    assign wr_en     = access && pwrite_i;
    assign is_data   = paddr_i == REG_DATA;
    assign woff      = paddr_i - REG_WEIGHT0;
    assign widx      = woff[5:2];
    assign is_weight = (paddr_i >= REG_WEIGHT0) && (woff < 8'(4 * N_TAPS));
    assign data_rd   = access && !pwrite_i && is_data;
    // Engine busy only while it runs on its own
    assign busy      = state_i == COMPUTE;

    // First data read cycle waits for the registered buffer output
    assign pready_o  = access && !(data_rd && !rd_wait_q);
    assign pslverr_o = 1'b0;

    assign start_o = wr_en && (paddr_i == REG_MAIN) && pwdata_i[0];
    assign load_o  = wr_en && (paddr_i == REG_MAIN) && pwdata_i[1];

    assign data_o.valid = access && is_data && !rd_wait_q;
    assign data_o.write = pwrite_i;
    assign data_o.wdata = pwdata_i[PIX_W-1:0];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_wait_q <= 1'b0;
            rd_ok_q   <= 1'b0;
            cfg_o     <= '0;
            weights_o <= '0;
        end else begin
            rd_wait_q <= data_rd && !rd_wait_q;
            if (data_rd && !rd_wait_q) begin
                rd_ok_q <= state_i == READACTS;
            end
            if (wr_en && (paddr_i == REG_CONFIG)) begin
                cfg_o <= pwdata_i[11:0];
            end
            if (wr_en && is_weight) begin
                weights_o.w[widx] <= pwdata_i[7:0];
            end
        end
    end

    // Read mux, weights come back sign extended
    always_comb begin
        prdata_o = '0;
        if (is_weight) begin
            prdata_o = {{24{weights_o.w[widx][7]}}, weights_o.w[widx]};
        end else begin
            case (paddr_i)
                REG_CONFIG: prdata_o = {20'b0, cfg_o};
                REG_STATUS: prdata_o = {29'b0, state_i, busy};
                REG_DATA:   prdata_o = rd_ok_q ? {24'b0, rd_data_i} : 32'b0;
                default:    prdata_o = '0;
            endcase
        end
    end

endmodule

// ==== source/qracc_mac.sv ====
// Accumulates one window per nine taps, then shifts and clamps to 0..255
// Result leaves one cycle after the last tap's pixel
module qracc_mac (
    input  logic                     clk,
    input  logic                     nrst,
    input  qracc_pkg::tap_t          tap_i,
    input  qracc_pkg::pixel_t        pixel_i,
    input  qracc_pkg::weights_t      weights_i,
    input  qracc_pkg::shift_t        shift_i,
    output qracc_pkg::mac_result_t   result_o
);
    import qracc_pkg::*;

    tap_t      tap_q;
    weight_t   w_sel;
    acc_t      prod;
    acc_t      acc_sum;
    acc_t      shifted;
    acc_t      acc_q;
    pixel_t    clamped;
    logic      res_valid_q;
    buf_addr_t res_oidx_q;
    pixel_t    res_value_q;

    // Stage one, tap lined up with the buffer data
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            tap_q <= '0;
        end else begin
            tap_q <= tap_i;
        end
    end

    always_comb begin
        w_sel   = weights_i.w[tap_q.widx];
        prod    = acc_t'(pixel_i) * acc_t'(w_sel);
        acc_sum = tap_q.first ? prod : acc_q + prod;
        shifted = acc_sum >>> shift_i;
        if (shifted < 0) begin
            clamped = '0;
        end else if (shifted > 255) begin
            clamped = 8'd255;
        end else begin
            clamped = shifted[PIX_W-1:0];
        end
    end

    ////////////////////////////////////////
    // Stage two, accumulate and emit
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= tap_q.valid && tap_q.last;
        end
    end

    always_ff @(posedge clk) begin
        if (tap_q.valid) begin
            acc_q <= acc_sum;
        end
        if (tap_q.valid && tap_q.last) begin
            res_oidx_q  <= tap_q.oidx;
            res_value_q <= clamped;
        end
    end

    assign result_o.valid = res_valid_q;
    assign result_o.oidx  = res_oidx_q;
    assign result_o.value = res_value_q;

endmodule

// ==== source/qracc_pkg.sv ====
// Shared sizes and types of the convolution accelerator
// One channel, 3x3 valid convolution, map sides 3..8, 128-entry buffer
package qracc_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int ADDR_W    = 7;
    localparam int BUF_DEPTH = 128;
    localparam int MAX_DIM   = 8;
    localparam int PIX_W     = 8;
    localparam int ACC_W     = 20;
    localparam int N_TAPS    = 9;

    typedef logic [PIX_W-1:0]              pixel_t;
    typedef logic signed [7:0]             weight_t;
    typedef logic signed [ACC_W-1:0]       acc_t;
    typedef logic [ADDR_W-1:0]             buf_addr_t;
    typedef logic [$clog2(MAX_DIM+1)-1:0]  dim_t;
    typedef logic [3:0]                    shift_t;

    // Output pixels start halfway up the buffer
    localparam buf_addr_t OFMAP_BASE = 7'd64;

    ////////////////////////////////////////
    // Register map, byte addresses
    ////////////////////////////////////////

    localparam logic [7:0] REG_MAIN    = 8'h00;
    localparam logic [7:0] REG_CONFIG  = 8'h04;
    localparam logic [7:0] REG_STATUS  = 8'h08;
    localparam logic [7:0] REG_DATA    = 8'h0C;
    localparam logic [7:0] REG_WEIGHT0 = 8'h10;

    // CONFIG word: dimx in [11:8], dimy in [7:4], shift in [3:0]
    typedef struct packed {
        dim_t   dimx;
        dim_t   dimy;
        shift_t shift;
    } qracc_config_t;

    // Tap index i = fy*3 + fx
    typedef struct packed {
        weight_t [N_TAPS-1:0] w;
    } weights_t;

    typedef struct packed {
        logic   valid;
        logic   write;
        pixel_t wdata;
    } data_access_t;

    typedef struct packed {
        logic      valid;
        logic      first;
        logic      last;
        buf_addr_t rd_addr;
        logic [3:0] widx;
        buf_addr_t oidx;
    } tap_t;

    typedef struct packed {
        logic      valid;
        buf_addr_t oidx;
        pixel_t    value;
    } mac_result_t;

    typedef struct packed {
        logic      en;
        logic      we;
        buf_addr_t addr;
        pixel_t    wdata;
    } buf_port_t;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        LOADACTS = 2'd1,
        COMPUTE  = 2'd2,
        READACTS = 2'd3
    } ctrl_state_t;

endpackage

// ==== source/qracc_top.sv ====
// Accelerator top, APB slave port only
module qracc_top (
    input  logic        clk,
    input  logic        nrst,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o
);
    import qracc_pkg::*;

    qracc_config_t cfg;
    weights_t      weights;
    data_access_t  data;
    tap_t          tap;
    mac_result_t   result;
    buf_port_t     buf_port;
    ctrl_state_t   state;
    pixel_t        rd_data;
    logic          start;
    logic          load;
    logic          run;
    logic          done;

    qracc_csr u_csr (
        .clk(clk), .nrst(nrst),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .state_i(state), .rd_data_i(rd_data), .cfg_o(cfg), .weights_o(weights),
        .start_o(start), .load_o(load), .data_o(data)
    );

    qracc_controller u_controller (
        .clk(clk), .nrst(nrst), .cfg_i(cfg), .start_i(start), .load_i(load),
        .data_i(data), .tap_i(tap), .done_i(done), .result_i(result),
        .run_o(run), .buf_o(buf_port), .state_o(state)
    );

    qracc_window_counter u_window_counter (
        .clk(clk), .nrst(nrst), .run_i(run), .cfg_i(cfg), .tap_o(tap), .done_o(done)
    );

    qracc_act_buffer u_act_buffer (
        .clk(clk), .port_i(buf_port), .rd_data_o(rd_data)
    );

    qracc_mac u_mac (
        .clk(clk), .nrst(nrst), .tap_i(tap), .pixel_i(rd_data),
        .weights_i(weights), .shift_i(cfg.shift), .result_o(result)
    );

endmodule

// ==== source/qracc_window_counter.sv ====
// Walks the 3x3 taps over every output pixel, row major
// One idle cycle after each first tap leaves room for the result write
module qracc_window_counter (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       run_i,
    input  qracc_pkg::qracc_config_t   cfg_i,
    output qracc_pkg::tap_t            tap_o,
    output logic                       done_o
);
    import qracc_pkg::*;

    dim_t       ox_q;
    dim_t       oy_q;
    logic [1:0] fx_q;
    logic [1:0] fy_q;
    logic       gap_q;
    logic       done_q;
    logic       emit;
    logic       first;
    logic       last;

    assign emit   = run_i && !gap_q && !done_q;
    assign first  = (fy_q == 2'd0) && (fx_q == 2'd0);
    assign last   = (fy_q == 2'd2) && (fx_q == 2'd2);
    assign done_o = done_q;

    always_comb begin
        tap_o.valid   = emit;
        tap_o.first   = first;
        tap_o.last    = last;
        tap_o.rd_addr = (oy_q + fy_q) * cfg_i.dimx + ox_q + fx_q;
        tap_o.widx    = 4'(fy_q) * 4'd3 + 4'(fx_q);
        tap_o.oidx    = OFMAP_BASE + oy_q * (cfg_i.dimx - 4'd2) + ox_q;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            {ox_q, oy_q, fx_q, fy_q, gap_q, done_q} <= '0;
        end else if (!run_i) begin
            {ox_q, oy_q, fx_q, fy_q, gap_q, done_q} <= '0;
        end else begin
            gap_q <= emit && first;
            if (emit) begin
                if (fx_q != 2'd2) begin
                    fx_q <= fx_q + 2'd1;
                end else begin
                    fx_q <= '0;
                    if (fy_q != 2'd2) begin
                        fy_q <= fy_q + 2'd1;
                    end else begin
                        fy_q <= '0;
                        if (ox_q != cfg_i.dimx - 4'd3) begin
                            ox_q <= ox_q + 4'd1;
                        end else begin
                            ox_q <= '0;
                            if (oy_q != cfg_i.dimy - 4'd3) begin
                                oy_q <= oy_q + 4'd1;
                            end else begin
                                // Last tap of the last window
                                done_q <= 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== sources.f ====
source/qracc_pkg.sv
source/qracc_act_buffer.sv
source/qracc_mac.sv
source/qracc_window_counter.sv
source/qracc_controller.sv
source/qracc_csr.sv
source/qracc_top.sv
verif/qracc_tb.sv

// ==== verif/qracc_tb.sv ====
// Self-checking testbench, APB host model with a reference convolution
// Stimulus from $random with a fixed seed; every wait is bounded
module qracc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import qracc_pkg::*;

    localparam int APB_TIMEOUT  = 20;
    localparam int POLL_LIMIT   = 400;
    localparam int N_RUNS       = 4;
    localparam int SAMPLE_DELAY = 10;

    logic        clk;
    logic        nrst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int      errors;
    int      checks;
    int      seed;
    pixel_t  ifmap [64];
    weight_t kernel [N_TAPS];
    pixel_t  model_out [36];

    qracc_top qracc_top_i (
        .clk(clk), .nrst(nrst),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Failure and compare helpers
    ////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_state(input ctrl_state_t got, input ctrl_state_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s: got state %s, expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_config(input qracc_config_t got, input qracc_config_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: config readback: got %h, expected %h",
                     $time, got, exp);
        end
    endtask

    task automatic check_weight(input weight_t got, input weight_t exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: weight %0d readback: got %0d, expected %0d",
                     $time, idx, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // APB host
    ////////////////////////////////////////

    // Access phase, sampled in the low half of each cycle before the completing edge
    task automatic wait_ready(output logic [31:0] rdata);
        int   cycles;
        logic ready;
        logic err;
        cycles = 0;
        ready  = 1'b0;
        err    = 1'b0;
        rdata  = '0;
        while (!ready && (cycles < APB_TIMEOUT)) begin
            #(SAMPLE_DELAY);
            ready = pready;
            rdata = prdata;
            err   = pslverr;
            @(negedge clk);
            cycles++;
        end
        if (!ready) begin
            abort_run("APB transfer timed out waiting for pready");
        end else begin
            check_flag(err, 1'b0, "pslverr on APB transfer");
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] dummy;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        wait_ready(dummy);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        wait_ready(data);
    endtask

    task automatic read_status(output ctrl_state_t st, output logic busy);
        logic [31:0] rd;
        apb_read(REG_STATUS, rd);
        st   = ctrl_state_t'(rd[2:1]);
        busy = rd[0];
    endtask

    task automatic wait_not_busy();
        int          polls;
        ctrl_state_t st;
        logic        busy;
        polls = 0;
        busy  = 1'b1;
        while (busy && (polls < POLL_LIMIT)) begin
            read_status(st, busy);
            polls++;
        end
        if (busy) begin
            abort_run("Compute pass did not finish, busy stayed high");
        end else begin
            check_state(st, READACTS, "state after compute");
        end
    endtask

    ////////////////////////////////////////
    // Reference model and test steps
    ////////////////////////////////////////

    // Valid 3x3 convolution, arithmetic shift, clamp to 0..255
    task automatic compute_model(input int dimx, input int dimy, input int shift);
        int sum;
        for (int oy = 0; oy < dimy - 2; oy++) begin
            for (int ox = 0; ox < dimx - 2; ox++) begin
                sum = 0;
                for (int fy = 0; fy < 3; fy++) begin
                    for (int fx = 0; fx < 3; fx++) begin
                        sum += int'(ifmap[(oy + fy) * dimx + ox + fx])
                               * int'(kernel[fy * 3 + fx]);
                    end
                end
                sum = sum >>> shift;
                if (sum < 0) begin
                    sum = 0;
                end else if (sum > 255) begin
                    sum = 255;
                end
                model_out[oy * (dimx - 2) + ox] = pixel_t'(sum);
            end
        end
    endtask

    task automatic set_config(input int dimx, input int dimy, input int shift);
        qracc_config_t cfg;
        logic [31:0]   rd;
        cfg.dimx  = dim_t'(dimx);
        cfg.dimy  = dim_t'(dimy);
        cfg.shift = shift_t'(shift);
        apb_write(REG_CONFIG, 32'(cfg));
        apb_read(REG_CONFIG, rd);
        check_config(qracc_config_t'(rd[11:0]), cfg);
    endtask

    task automatic set_weights();
        logic [31:0] rd;
        for (int i = 0; i < N_TAPS; i++) begin
            apb_write(REG_WEIGHT0 + 8'(4 * i), {{24{kernel[i][7]}}, kernel[i]});
        end
        for (int i = 0; i < N_TAPS; i++) begin
            apb_read(REG_WEIGHT0 + 8'(4 * i), rd);
            check_weight(weight_t'(rd[7:0]), kernel[i], i);
        end
    endtask

    task automatic load_map(input int dimx, input int dimy);
        ctrl_state_t st;
        logic        busy;
        apb_write(REG_MAIN, 32'h2);
        for (int i = 0; i < dimx * dimy; i++) begin
            apb_write(REG_DATA, {24'b0, ifmap[i]});
        end
        read_status(st, busy);
        check_state(st, IDLE, "state after load");
    endtask

    // Start, wait for the end of compute, then read back every output pixel
    task automatic compute_and_check(input int dimx, input int dimy, input int shift);
        logic [31:0] rd;
        ctrl_state_t st;
        logic        busy;
        compute_model(dimx, dimy, shift);
        apb_write(REG_MAIN, 32'h1);
        wait_not_busy();
        for (int i = 0; i < (dimx - 2) * (dimy - 2); i++) begin
            apb_read(REG_DATA, rd);
            check_pixel(rd[7:0], model_out[i],
                        $sformatf("output %0d of %0dx%0d map", i, dimx, dimy));
        end
        read_status(st, busy);
        check_state(st, IDLE, "state after readback");
        check_flag(busy, 1'b0, "busy after readback");
    endtask

    task automatic random_run(input int dimx, input int dimy, input int shift,
                              input int wfix);
        for (int i = 0; i < 64; i++) begin
            ifmap[i] = pixel_t'($random(seed));
        end
        for (int i = 0; i < N_TAPS; i++) begin
            kernel[i] = (wfix == 0) ? weight_t'($random(seed)) : weight_t'(wfix);
        end
        set_weights();
        set_config(dimx, dimy, shift);
        load_map(dimx, dimy);
        compute_and_check(dimx, dimy, shift);
    endtask

    initial begin
        ctrl_state_t st;
        logic        busy;
        logic [31:0] rd;
        int          dimx;
        int          dimy;
        int          shift;
        seed    = 32'h4b13;
        errors  = 0;
        checks  = 0;
        nrst    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        // Idle after reset, data window reads zero
        read_status(st, busy);
        check_state(st, IDLE, "state after reset");
        check_flag(busy, 1'b0, "busy after reset");
        apb_read(REG_DATA, rd);
        check_pixel(rd[7:0], 8'd0, "data read in IDLE after reset");

        // Random maps, back to back with new sizes
        for (int r = 0; r < N_RUNS; r++) begin
            dimx  = 3 + ({$random(seed)} % 6);
            dimy  = 3 + ({$random(seed)} % 6);
            shift = {$random(seed)} % 8;
            random_run(dimx, dimy, shift, 0);
        end

        // Saturation at both ends
        random_run(8, 8, 0, 127);
        random_run(5, 7, 0, -128);

        // Stray data accesses in IDLE, then a rerun over the same map
        for (int i = 0; i < 6; i++) begin
            apb_write(REG_DATA, $random(seed));
        end
        apb_read(REG_DATA, rd);
        check_pixel(rd[7:0], 8'd0, "data read in IDLE after run");
        compute_and_check(5, 7, 0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
